//--- src/dma_write_params.svh
`ifndef DMA_WRITE_PARAMS_SVH
`define DMA_WRITE_PARAMS_SVH

// Bus widths
`define DMA_DATA_WIDTH 32
`define DMA_ADDR_WIDTH 32

// Request length field holds bytes minus one
`define DMA_LEN_WIDTH 24

// Burst shaping
`define DMA_MAX_BURST 16
`define DMA_BOUNDARY 4096
`define DMA_MAX_OUTSTANDING 4

// The full flag needs a power of two depth
`define DMA_FIFO_DEPTH 64

`endif

//--- src/dma_write_pkg.sv
`default_nettype none

`include "dma_write_params.svh"

package dma_write_pkg;

  localparam logic [2:0] AXI_SIZE_WORD = 3'($clog2(`DMA_DATA_WIDTH / 8));
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
  localparam logic [2:0] AXI_PROT_DEFAULT = 3'b000;
  localparam logic [3:0] AXI_CACHE_DEFAULT = 4'b0011; // Bufferable, modifiable

  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] addr;
    logic [`DMA_LEN_WIDTH-1:0]  len;  // Bytes minus one
  } dma_req_t;

  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] awaddr;
    logic [7:0]                 awlen;
    logic [2:0]                 awsize;
    logic [1:0]                 awburst;
    logic [2:0]                 awprot;
    logic [3:0]                 awcache;
  } axi_aw_t;

  typedef struct packed {
    logic [`DMA_DATA_WIDTH-1:0]   wdata;
    logic [`DMA_DATA_WIDTH/8-1:0] wstrb;
    logic                         wlast;
  } axi_w_t;

  // One burst as handed from a counter to its consumer
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] addr;
    logic [7:0]                 beats; // Beat count minus one
  } burst_t;

endpackage

`default_nettype wire

//--- src/dma_burst_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_write_params.svh"

module dma_burst_counter (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        start,
  input  wire dma_write_pkg::dma_req_t req,
  input  wire                        step,  // Current burst has been used
  output dma_write_pkg::burst_t      burst,
  output logic                       last_burst
);

  localparam int ADDR_BITS = `DMA_ADDR_WIDTH;
  localparam int REM_BITS = `DMA_LEN_WIDTH - 2;
  localparam int BND_BITS = $clog2(`DMA_BOUNDARY);

  logic [ADDR_BITS-1:0] addr;
  logic [REM_BITS-1:0]  rem_m1;    // Words still to move, minus one
  logic [BND_BITS-3:0]  bnd_m1;
  logic [7:0]           beats_m1;
  logic [BND_BITS:0]    burst_end;

  // Words up to the next boundary, minus one
  assign bnd_m1 = ~addr[BND_BITS-1:2];

  always_comb begin
    beats_m1 = 8'(`DMA_MAX_BURST - 1);
    if (bnd_m1 < beats_m1) begin
      beats_m1 = 8'(bnd_m1);
    end
    if (rem_m1 < beats_m1) begin
      beats_m1 = 8'(rem_m1);
    end
  end

  assign burst = '{addr: addr, beats: beats_m1};
  assign last_burst = (rem_m1 == REM_BITS'(beats_m1));

  always_ff @(posedge clk) begin
    if (reset) begin
      addr <= '0;
      rem_m1 <= '0;
    end else if (start) begin
      addr <= req.addr;
      rem_m1 <= req.len[`DMA_LEN_WIDTH-1:2];
    end else if (step) begin
      addr <= addr + (ADDR_BITS'(beats_m1) + 1'b1) * (`DMA_DATA_WIDTH / 8);
      rem_m1 <= rem_m1 - REM_BITS'(beats_m1) - 1'b1;
    end
  end

  // Byte offset just past the burst, relative to the boundary
  assign burst_end = {1'b0, addr[BND_BITS-1:0]} + {beats_m1 + 8'd1, 2'b00};

  assert property (@(posedge clk) disable iff (reset)
    step |-> burst_end <= `DMA_BOUNDARY);

endmodule

`default_nettype wire

//--- src/dma_data_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_write_params.svh"

module dma_data_fifo (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        start,
  input  wire [`DMA_LEN_WIDTH-3:0]   total_words,  // Word count minus one
  input  wire                        wr_en,
  input  wire [`DMA_DATA_WIDTH-1:0]  wr_data,
  output logic                       xfer_req,
  output logic                       overflow,
  input  wire                        rd_en,
  output logic [`DMA_DATA_WIDTH-1:0] rd_data,
  output logic                       rd_valid
);

  localparam int PTR_BITS = $clog2(`DMA_FIFO_DEPTH);

  logic [`DMA_DATA_WIDTH-1:0] mem [`DMA_FIFO_DEPTH];
  logic [PTR_BITS-1:0]        wr_ptr;
  logic [PTR_BITS-1:0]        rd_ptr;
  logic [PTR_BITS:0]          count;
  logic [`DMA_LEN_WIDTH-3:0]  accepted;
  logic [`DMA_LEN_WIDTH-3:0]  last_word;
  logic                       full;
  logic                       wr_ok;

  assign full = count[PTR_BITS];
  assign rd_valid = (count != '0);
  assign rd_data = mem[rd_ptr];

  // Writes outside the request window are not taken
  assign wr_ok = wr_en && xfer_req && !full;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      last_word <= total_words; // The request is only valid with the strobe
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      accepted <= '0;
      xfer_req <= 1'b0;
      overflow <= 1'b0;
    end else begin
      overflow <= wr_en && xfer_req && full;
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{PTR_BITS{1'b0}}, wr_ok} - {{PTR_BITS{1'b0}}, rd_en};

      if (start) begin
        xfer_req <= 1'b1;
        accepted <= '0;
      end else if (wr_ok) begin
        if (accepted == last_word) begin
          xfer_req <= 1'b0;  // Every word of the transfer is in
        end
        accepted <= accepted + 1'b1;
      end
    end
  end

  // The W channel must only pop a word that is there
  assert property (@(posedge clk) disable iff (reset)
    rd_en |-> rd_valid);

endmodule

`default_nettype wire

//--- src/axi_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_write_params.svh"

module axi_write_channel (
  input  wire                       clk,
  input  wire                       reset,
  input  wire dma_write_pkg::burst_t burst,
  output logic                      step,
  output logic                      rd_en,
  input  wire [`DMA_DATA_WIDTH-1:0] rd_data,
  input  wire                       rd_valid,
  output logic                      wvalid,
  output dma_write_pkg::axi_w_t     w,
  input  wire                       wready
);

  logic [7:0] beat;        // Position within the current burst
  logic       final_beat;

  assign final_beat = (beat == burst.beats);

  // Pop whenever the output register is free or being emptied this cycle
  assign rd_en = rd_valid && (!wvalid || wready);

  // Stepping as the last beat is taken leaves the next length ready for the following pop
  assign step = rd_en && final_beat;

  always_ff @(posedge clk) begin
    if (reset) begin
      wvalid <= 1'b0;
      beat <= '0;
    end else begin
      if (rd_en) begin
        wvalid <= 1'b1;
        beat <= final_beat ? 8'd0 : beat + 8'd1;
      end else if (wready) begin
        wvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      w.wdata <= rd_data;
      w.wstrb <= '1;  // Full words only
      w.wlast <= final_beat;
    end
  end

endmodule

`default_nettype wire

//--- src/dma_transfer_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_write_params.svh"

module dma_transfer_fsm (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      req_valid,
  input  wire dma_write_pkg::dma_req_t req,
  output logic                     busy,
  output logic                     start,
  input  wire dma_write_pkg::burst_t burst,
  input  wire                      last_burst,
  output logic                     burst_step,
  output logic                     awvalid,
  output dma_write_pkg::axi_aw_t   aw,
  input  wire                      awready,
  input  wire                      bvalid,
  input  wire [1:0]                bresp,
  output logic                     bready,
  output logic                     eot,
  output logic                     eot_error
);
  import dma_write_pkg::*;

  typedef enum logic [1:0] {
    idle,
    address,
    drain,
    done
  } state_t;

  state_t     state;
  logic [2:0] outstanding;
  logic [2:0] outstanding_next;
  logic       accept;
  logic       aw_hs;
  logic       b_hs;
  logic       error;

  assign accept = req_valid && !busy; // Strobes while busy are dropped
  assign start = accept;
  assign busy = (state == address) || (state == drain);
  assign eot = (state == done);
  assign eot_error = error;

  assign aw_hs = awvalid && awready;
  assign b_hs = bvalid && bready;
  assign burst_step = aw_hs;
  assign outstanding_next = outstanding + {2'b00, aw_hs} - {2'b00, b_hs};

  // The counter only moves on a handshake, so the payload holds while awvalid waits
  assign aw = '{
    awaddr:  burst.addr,
    awlen:   burst.beats,
    awsize:  AXI_SIZE_WORD,
    awburst: AXI_BURST_INCR,
    awprot:  AXI_PROT_DEFAULT,
    awcache: AXI_CACHE_DEFAULT
  };

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      awvalid <= 1'b0;
      outstanding <= '0;
      error <= 1'b0;
      bready <= 1'b0;
    end else begin
      bready <= 1'b1;
      outstanding <= outstanding_next;

      if (accept) begin
        error <= 1'b0;
      end else if (b_hs && bresp != AXI_RESP_OKAY) begin
        error <= 1'b1; // Sticky until the next request
      end

      case (state)
        idle, done: begin
          state <= accept ? address : idle;
        end
        address: begin
          if (aw_hs && last_burst) begin
            state <= drain;
            awvalid <= 1'b0;
          end else if (!awvalid || awready) begin
            // Next burst goes out only while the response window has room
            awvalid <= (outstanding_next < `DMA_MAX_OUTSTANDING);
          end
        end
        drain: begin
          if (outstanding_next == '0) begin
            state <= done;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Address channel must hold its request until the slave takes it
  assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(aw));

  // Only whole, aligned words are supported
  assert property (@(posedge clk) disable iff (reset)
    accept |-> req.addr[1:0] == 2'b00 && req.len[1:0] == 2'b11);

endmodule

`default_nettype wire

//--- src/dma_write_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_write_params.svh"

module dma_write_top (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        req_valid,
  input  wire dma_write_pkg::dma_req_t req,
  output logic                       busy,
  output logic                       eot,
  output logic                       eot_error,
  output logic                       fifo_wr_xfer_req,
  input  wire                        fifo_wr_en,
  input  wire [`DMA_DATA_WIDTH-1:0]  fifo_wr_din,
  output logic                       fifo_wr_overflow,
  output logic                       awvalid,
  output dma_write_pkg::axi_aw_t     aw,
  input  wire                        awready,
  output logic                       wvalid,
  output dma_write_pkg::axi_w_t      w,
  input  wire                        wready,
  input  wire                        bvalid,
  input  wire [1:0]                  bresp,
  output logic                       bready
);
  import dma_write_pkg::*;

  logic                       start;
  logic                       burst_step;
  logic                       addr_last;
  logic                       data_step;
  logic                       rd_en;
  logic                       rd_valid;
  logic [`DMA_DATA_WIDTH-1:0] rd_data;
  burst_t                     addr_burst;
  burst_t                     data_burst;

  dma_transfer_fsm i_fsm (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req(req), .busy(busy), .start(start),
    .burst(addr_burst), .last_burst(addr_last), .burst_step(burst_step),
    .awvalid(awvalid), .aw(aw), .awready(awready),
    .bvalid(bvalid), .bresp(bresp), .bready(bready),
    .eot(eot), .eot_error(eot_error)
  );

  // Both counters see the same request, so they walk the same bursts
  dma_burst_counter i_addr_counter (
    .clk(clk), .reset(reset), .start(start), .req(req),
    .step(burst_step), .burst(addr_burst), .last_burst(addr_last)
  );

  dma_burst_counter i_data_counter (
    .clk(clk), .reset(reset), .start(start), .req(req),
    .step(data_step), .burst(data_burst), .last_burst()
  );

  dma_data_fifo i_fifo (
    .clk(clk), .reset(reset), .start(start),
    .total_words(req.len[`DMA_LEN_WIDTH-1:2]),
    .wr_en(fifo_wr_en), .wr_data(fifo_wr_din),
    .xfer_req(fifo_wr_xfer_req), .overflow(fifo_wr_overflow),
    .rd_en(rd_en), .rd_data(rd_data), .rd_valid(rd_valid)
  );

  axi_write_channel i_w_channel (
    .clk(clk), .reset(reset), .burst(data_burst), .step(data_step),
    .rd_en(rd_en), .rd_data(rd_data), .rd_valid(rd_valid),
    .wvalid(wvalid), .w(w), .wready(wready)
  );

endmodule

`default_nettype wire

//--- sim/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_write_params.svh"

module axi_mem_model #(
  parameter int SEED = 98,
  parameter int WORDS = 4096
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        awvalid,
  input  wire dma_write_pkg::axi_aw_t aw,
  output logic                       awready,
  input  wire                        wvalid,
  input  wire dma_write_pkg::axi_w_t  w,
  output logic                       wready,
  output logic                       bvalid,
  output logic [1:0]                 bresp,
  input  wire                        bready,
  input  wire [31:0]                 err_lo,  // Beats in this byte range get SLVERR
  input  wire [31:0]                 err_hi
);
  import dma_write_pkg::*;

  logic [31:0] mem [WORDS];
  axi_aw_t     aw_q [$];   // Accepted bursts still waiting for data
  logic [1:0]  b_q [$];
  integer      seed = SEED;
  int          beat = 0;
  logic        slverr = 1'b0;
  logic [31:0] a;
  int          aw_seen = 0;
  int          too_long = 0;
  int          crossed = 0;
  int          bad_last = 0;
  int          bad_type = 0;

  initial begin
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bresp = 2'b00;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = ~(32'(i) * 4); // Unwritten words read back as the inverted byte address
    end
  end

  always @(posedge clk) begin
    if (bvalid && bready) begin
      void'(b_q.pop_front());
    end
    if (awvalid && awready) begin
      aw_q.push_back(aw);
      aw_seen++;
      if (aw.awlen >= `DMA_MAX_BURST) too_long++;
      if (int'(aw.awaddr % `DMA_BOUNDARY) + (int'(aw.awlen) + 1) * 4 > `DMA_BOUNDARY) crossed++;
      // Every burst moves whole 4-byte words with incrementing addresses
      if (aw.awsize != 3'd2 || aw.awburst != 2'b01) bad_type++;
    end
    if (wvalid && wready) begin
      a = aw_q[0].awaddr + 32'(4 * beat);
      if (a >= err_lo && a <= err_hi) begin
        slverr = 1'b1; // Beat is refused and the word stays untouched
      end else begin
        mem[(a >> 2) % WORDS] = w.wdata;
      end
      if (w.wlast != (beat == int'(aw_q[0].awlen))) bad_last++;
      if (w.wlast) begin
        b_q.push_back(slverr ? 2'b10 : 2'b00);
        slverr = 1'b0;
        beat = 0;
        void'(aw_q.pop_front());
      end else begin
        beat++;
      end
    end
  end

  // Ready and response signals change on the falling edge only
  always @(negedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      bresp <= 2'b00;
    end else begin
      awready <= ($random(seed) & 3) != 0;
      wready <= (aw_q.size() != 0) && (($random(seed) & 3) != 0);
      bvalid <= b_q.size() != 0;
      bresp <= (b_q.size() != 0) ? b_q[0] : 2'b00;
    end
  end

endmodule

`default_nettype wire

//--- sim/dma_write_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dma_write_params.svh"

module dma_write_tb;
  import dma_write_pkg::*;

  localparam int short_words = 4;
  localparam int boundary_words = 100;
  localparam int b2b_words = 8 + 9 + 10 + 11;
  localparam int error_words = 32;
  localparam int watchdog_cycles =
    200 * (short_words + boundary_words + b2b_words + error_words);
  localparam logic [31:0] stray_addr = 32'h0000_3000;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic req_valid = 1'b0;
  dma_req_t req = '0;
  logic busy, eot, eot_error, fifo_wr_xfer_req, fifo_wr_overflow;
  logic fifo_wr_en = 1'b0;
  logic [`DMA_DATA_WIDTH-1:0] fifo_wr_din = '0;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  axi_aw_t aw;
  axi_w_t w;
  logic [1:0] bresp;
  logic [31:0] err_lo = '1;
  logic [31:0] err_hi = '0;
  integer seed = 98;
  logic [31:0] src_base = '0;
  int src_count = 0;
  int eot_count = 0;

  always #4 clk = ~clk;

  dma_write_top i_dma_write_top (
    .clk(clk), .reset(reset), .req_valid(req_valid), .req(req), .busy(busy),
    .eot(eot), .eot_error(eot_error), .fifo_wr_xfer_req(fifo_wr_xfer_req),
    .fifo_wr_en(fifo_wr_en), .fifo_wr_din(fifo_wr_din), .fifo_wr_overflow(fifo_wr_overflow),
    .awvalid(awvalid), .aw(aw), .awready(awready), .wvalid(wvalid), .w(w), .wready(wready),
    .bvalid(bvalid), .bresp(bresp), .bready(bready)
  );

  axi_mem_model #(.SEED(98)) i_mem (
    .clk(clk), .reset(reset), .awvalid(awvalid), .aw(aw), .awready(awready),
    .wvalid(wvalid), .w(w), .wready(wready), .bvalid(bvalid), .bresp(bresp),
    .bready(bready), .err_lo(err_lo), .err_hi(err_hi)
  );

  task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  // Bursts stop at 16 beats and at every 4 KB boundary
  function automatic int burst_count(input int addr, input int words);
    int n = 0;
    int chunk;
    while (words > 0) begin
      chunk = (`DMA_BOUNDARY - addr % `DMA_BOUNDARY) / 4;
      if (chunk > `DMA_MAX_BURST) chunk = `DMA_MAX_BURST;
      if (chunk > words) chunk = words;
      addr += chunk * 4;
      words -= chunk;
      n++;
    end
    return n;
  endfunction

  // Source offers a word about one cycle in four, only inside the request window
  always @(negedge clk) begin
    fifo_wr_en = fifo_wr_xfer_req && (($random(seed) & 3) == 0);
    if (fifo_wr_en) begin
      fifo_wr_din = src_base + 32'(4 * src_count);
      src_count++;
    end
  end

  always @(negedge clk) begin
    if (eot) eot_count++;
    if (!reset && fifo_wr_overflow) begin
      $display("FIFO overflow pulsed although the source only wrote inside its window");
      stop_with_failure();
    end
  end

  task automatic check_idle_after_reset();
    repeat (5) begin
      @(negedge clk);
      check(busy, 0, "busy after reset");
      check(awvalid, 0, "awvalid after reset");
      check(wvalid, 0, "wvalid after reset");
      check(eot, 0, "eot after reset");
      check(fifo_wr_xfer_req, 0, "source request after reset");
      check(bready, 1, "bready after reset");
    end
  endtask

  task automatic run_transfer(input logic [31:0] addr, input int words, input logic [31:0] base,
                              input logic [31:0] bad_lo, input logic [31:0] bad_hi,
                              input bit stray);
    int eots;
    int aws;
    int cycles;
    logic [31:0] a;
    bit expect_err;
    eots = eot_count;
    aws = i_mem.aw_seen;
    expect_err = 0;
    for (int k = 0; k < words; k++) begin
      a = addr + 32'(4 * k);
      if (a >= bad_lo && a <= bad_hi) expect_err = 1;
    end
    err_lo = bad_lo;
    err_hi = bad_hi;
    src_base = base;
    src_count = 0;
    req_valid = 1'b1;
    req = '{addr: addr, len: 24'(words * 4 - 1)};
    @(negedge clk);
    req_valid = 1'b0;
    check(busy, 1, "busy one cycle after the request");
    check(fifo_wr_xfer_req, 1, "source request one cycle after the request");
    if (stray) begin
      repeat (3) @(negedge clk);
      req_valid = 1'b1;  // Arrives while busy and must be dropped
      req = '{addr: stray_addr, len: 24'd255};
      @(negedge clk);
      req_valid = 1'b0;
    end
    cycles = 0;
    while (!eot) begin
      if (cycles == 200 * words + 100) begin
        $display("Timed out waiting for the end of the transfer to %h", addr);
        stop_with_failure();
      end
      @(negedge clk);
      cycles++;
    end
    check(eot_error, expect_err, "eot_error");
    check(busy, 0, "busy with eot");
    check(fifo_wr_xfer_req, 0, "source request at eot");
    check(src_count, words, "words taken from the source");
    repeat (4) @(negedge clk);
    check(eot_count, eots + 1, "eot pulses for one request");
    check(i_mem.aw_seen - aws, burst_count(addr, words), "bursts issued");
    check(i_mem.too_long, 0, "bursts longer than 16 beats");
    check(i_mem.crossed, 0, "bursts crossing a 4 KB boundary");
    check(i_mem.bad_last, 0, "wlast not matching awlen");
    check(i_mem.bad_type, 0, "bursts not word sized or not incrementing");
    for (int k = 0; k < words; k++) begin
      a = addr + 32'(4 * k);
      if (a >= bad_lo && a <= bad_hi) begin
        check(i_mem.mem[(a >> 2) % 4096], ~a, "word inside the error window");
      end else begin
        check(i_mem.mem[(a >> 2) % 4096], base + 32'(4 * k), "written word");
      end
    end
    for (int k = 0; stray && k < 64; k++) begin
      a = stray_addr + 32'(4 * k);
      check(i_mem.mem[(a >> 2) % 4096], ~a, "memory of the ignored request");
    end
  endtask

  initial begin
    repeat (16) @(negedge clk);
    reset = 1'b0;
    check_idle_after_reset();
    run_transfer(32'h0000_0100, short_words, 32'h1000_0000, '1, '0, 0);
    run_transfer(32'h0000_0fd8, boundary_words, 32'h2000_0000, '1, '0, 0);
    for (int i = 0; i < 4; i++) begin
      run_transfer(32'h0000_1800 + 32'(i * 256), 8 + i, 32'h3000_0000 + 32'(i << 16),
                   '1, '0, i == 1);
    end
    // Second burst of the transfer falls in the window
    run_transfer(32'h0000_2000, error_words, 32'h4000_0000, 32'h0000_2040, 32'h0000_207c, 0);
    $display("Verification passed");
    $finish;
  end

  initial begin
    #(watchdog_cycles * 8);
    $display("Watchdog expired before all tests finished");
    stop_with_failure();
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
src/dma_write_pkg.sv
src/dma_burst_counter.sv
src/dma_data_fifo.sv
src/axi_write_channel.sv
src/dma_transfer_fsm.sv
src/dma_write_top.sv
sim/axi_mem_model.sv
sim/dma_write_tb.sv
